//--- dv/husky_checker.sv
module husky_checker (
   input logic                             clk_usb_buf,
   input logic                             arst_n_i,
   input husky_pkg::host_pins_t            host_i,
   input logic [husky_pkg::ADDR_W-1:0]     usb_addr_i,
   input logic [husky_pkg::DATA_W-1:0]     usb_data_i,
   input logic [husky_pkg::DATA_W-1:0]     usb_data_o,
   input logic                             usb_data_oe_o,
   input logic                             sam_mosi_i,
   input logic                             sam_spck_i,
   input logic                             sam_miso_o,
   input logic                             sam_miso_oe_o,
   input logic                             target_miso_i,
   input logic                             target_poweron_o,
   input logic                             target_nrst_o,
   input logic                             target_nrst_oe_o,
   input logic                             target_mosi_o,
   input logic                             target_mosi_oe_o,
   input logic                             target_sck_o,
   input logic                             target_sck_oe_o,
   input logic [husky_pkg::ERR_SRC_N-1:0]  err_src_i,
   input logic                             pll_status_i,
   input logic                             led_glitch_i,
   input logic                             led_adc_o,
   input logic                             led_glitch_o
);
   import husky_pkg::*;

   localparam logic [3:0] SETTLE_CYC = 4'd6;  // covers the 4-cycle write-to-pin latency

   typedef struct packed {
      logic poweron;
      logic nrst_oe;
      logic nrst;
      logic mosi_oe;
      logic mosi;
      logic sck_oe;
      logic sck;
      logic miso_oe;
      logic miso;
   } pin_state_t;

   int unsigned fail_cnt = 0;

   host_pins_t           host_q;
   logic [ADDR_W-1:0]    addr_sh;
   logic [BYTECNT_W-1:0] bytecnt_sh;
   logic [DATA_W-1:0]    ctrl_sh;
   logic [ERR_SRC_N-1:0] flags_sh;
   logic [DATA_W-1:0]    rd_next;
   logic [DATA_W-1:0]    rd_exp;
   logic                 in_read;
   logic [3:0]           rd_low_cnt;
   logic [3:0]           rd_high_cnt;
   logic [3:0]           settle_cnt;
   logic                 settled;
   logic                 ale_fall;
   logic                 wr_rise;
   logic                 rd_fall;
   logic                 rd_rise;
   logic [ERR_SRC_N-1:0] clr_mask;
   logic                 powered;
   logic                 prog;
   pin_state_t           pins_exp;
   pin_state_t           pins_act;
   logic [1:0]           leds_exp;

   // host edges seen directly at the pins
   assign ale_fall = host_q.ale_n & ~host_i.ale_n & ~host_i.ce_n;
   assign wr_rise  = ~host_q.wr_n & host_i.wr_n & ~host_i.ce_n;
   assign rd_fall  = host_q.rd_n & ~host_i.rd_n & ~host_i.ce_n;
   assign rd_rise  = ~host_q.rd_n & host_i.rd_n;
   assign clr_mask = (wr_rise && addr_sh == REG_STATUS) ? usb_data_i[ERR_SRC_N-1:0] : '0;
   assign settled  = (settle_cnt >= SETTLE_CYC);

   // value the host should read back
   always_comb begin
      rd_next = '0;
      if (addr_sh == REG_TARGET_CTRL && bytecnt_sh == '0) begin
         rd_next = ctrl_sh;
      end else if (addr_sh == REG_STATUS) begin
         rd_next = {{(DATA_W-ERR_SRC_N-1){1'b0}}, pll_status_i, flags_sh};
      end
   end

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         host_q     <= '1;
         addr_sh    <= '0;
         bytecnt_sh <= '0;
         ctrl_sh    <= CTRL_RESET_VALUE;
         flags_sh   <= '0;
         rd_exp     <= '0;
         in_read    <= 1'b0;
      end else begin
         host_q   <= host_i;
         flags_sh <= (flags_sh & ~clr_mask) | err_src_i;  // sticky, set wins
         if (ale_fall) begin
            addr_sh    <= usb_addr_i;
            bytecnt_sh <= '0;
         end else if (wr_rise || (rd_rise && in_read)) begin
            bytecnt_sh <= bytecnt_sh + 1'b1;
         end
         if (wr_rise && addr_sh == REG_TARGET_CTRL && bytecnt_sh == '0) begin
            ctrl_sh <= usb_data_i;
         end
         if (rd_fall) begin
            rd_exp  <= rd_next;
            in_read <= 1'b1;
         end else if (rd_rise) begin
            in_read <= 1'b0;
         end
      end
   end

   // strobe length and quiet-time counters, saturating
   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_low_cnt  <= '0;
         rd_high_cnt <= '1;
         settle_cnt  <= SETTLE_CYC;  // reset values are already known
      end else begin
         if (host_i.rd_n || host_i.ce_n) begin
            rd_low_cnt <= '0;
         end else if (rd_low_cnt != '1) begin
            rd_low_cnt <= rd_low_cnt + 1'b1;
         end
         if (!host_i.rd_n) begin
            rd_high_cnt <= '0;
         end else if (rd_high_cnt != '1) begin
            rd_high_cnt <= rd_high_cnt + 1'b1;
         end
         if (wr_rise) begin
            settle_cnt <= '0;
         end else if (settle_cnt < SETTLE_CYC) begin
            settle_cnt <= settle_cnt + 1'b1;
         end
      end
   end

   // expected target pins, undriven outputs compare as zero
   always_comb begin
      powered          = ~ctrl_sh[CTRL_POWER_OFF];
      prog             = powered & ctrl_sh[CTRL_AVRPROG];
      pins_exp         = '0;
      pins_exp.poweron = powered;
      pins_exp.miso_oe = ctrl_sh[CTRL_AVRPROG];
      pins_exp.miso    = target_miso_i;
      if (prog) begin
         pins_exp.nrst_oe = 1'b1;  // held low
         pins_exp.mosi_oe = 1'b1;
         pins_exp.mosi    = sam_mosi_i;
         pins_exp.sck_oe  = 1'b1;
         pins_exp.sck     = sam_spck_i;
      end else if (powered && ctrl_sh[CTRL_NRST_EN]) begin
         pins_exp.nrst_oe = 1'b1;
         pins_exp.nrst    = ctrl_sh[CTRL_NRST_VAL];
      end
      leds_exp = (flags_sh != '0) ? 2'b00 : {~pll_status_i, led_glitch_i};
   end

   always_comb begin
      pins_act.poweron = target_poweron_o;
      pins_act.nrst_oe = target_nrst_oe_o;
      pins_act.nrst    = target_nrst_oe_o & target_nrst_o;
      pins_act.mosi_oe = target_mosi_oe_o;
      pins_act.mosi    = target_mosi_oe_o & target_mosi_o;
      pins_act.sck_oe  = target_sck_oe_o;
      pins_act.sck     = target_sck_oe_o & target_sck_o;
      pins_act.miso_oe = sam_miso_oe_o;
      pins_act.miso    = sam_miso_o;
   end

   a_pins : assert property (@(posedge clk_usb_buf) disable iff (!arst_n_i)
      settled |-> (pins_act == pins_exp))
      else begin
         fail_cnt++;
         $error("[ERROR] target pins got %h exp %h", pins_act, pins_exp);
      end

   a_leds : assert property (@(posedge clk_usb_buf) disable iff (!arst_n_i)
      settled |-> ({led_adc_o, led_glitch_o} == leds_exp))
      else begin
         fail_cnt++;
         $error("[ERROR] led_adc_o/led_glitch_o got %h exp %h", {led_adc_o, led_glitch_o},
                leds_exp);
      end

   a_rdata : assert property (@(posedge clk_usb_buf) disable iff (!arst_n_i)
      usb_data_oe_o |-> (usb_data_o == rd_exp))
      else begin
         fail_cnt++;
         $error("[ERROR] usb_data_o got %h exp %h", usb_data_o, rd_exp);
      end

   a_oe_on : assert property (@(posedge clk_usb_buf) disable iff (!arst_n_i)
      (rd_low_cnt >= 6) |-> usb_data_oe_o)
      else begin
         fail_cnt++;
         $error("read data was not driven while the host held RDn low");
      end

   a_oe_off : assert property (@(posedge clk_usb_buf) disable iff (!arst_n_i)
      (rd_high_cnt >= 4) |-> !usb_data_oe_o)
      else begin
         fail_cnt++;
         $error("read data still driven after the host released RDn");
      end

endmodule

bind husky_top husky_checker u_checker (.*);

//--- dv/tb_husky_top.sv
module tb_husky_top;
   import husky_pkg::*;

   localparam int unsigned CLK_PERIOD  = 10;
   localparam int unsigned RESET_CYC   = 16;
   localparam int unsigned STROBE_CYC  = 8;     // host strobe low and high time
   localparam int unsigned TIMEOUT_CYC = 4000;
   localparam logic [31:0] SEED        = 32'h4d9d_475a;
   localparam logic [ADDR_W-1:0] REG_UNMAPPED = 8'h5a;

   logic                 clk_usb_buf;
   logic                 arst_n_i;
   host_pins_t           host_i;
   logic [ADDR_W-1:0]    usb_addr_i;
   logic [DATA_W-1:0]    usb_data_i;
   logic [DATA_W-1:0]    usb_data_o;
   logic                 usb_data_oe_o;
   logic                 sam_mosi_i;
   logic                 sam_spck_i;
   logic                 sam_miso_o;
   logic                 sam_miso_oe_o;
   logic                 target_miso_i;
   logic                 target_poweron_o;
   logic                 target_nrst_o;
   logic                 target_nrst_oe_o;
   logic                 target_mosi_o;
   logic                 target_mosi_oe_o;
   logic                 target_sck_o;
   logic                 target_sck_oe_o;
   logic [ERR_SRC_N-1:0] err_src_i;
   logic                 pll_status_i;
   logic                 led_glitch_i;
   logic                 led_adc_o;
   logic                 led_glitch_o;

   logic [31:0] rnd;
   int unsigned err_cnt = 0;
   int unsigned cycle_cnt = 0;

   husky_top UUT (.*);

   initial begin
      clk_usb_buf = 1'b0;
      forever #(CLK_PERIOD / 2) clk_usb_buf = ~clk_usb_buf;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic wait_cycles(input int unsigned n);
      repeat (n) @(negedge clk_usb_buf);
   endtask

   task automatic start_access(input logic [ADDR_W-1:0] addr);
      host_i.ce_n = 1'b0;
      usb_addr_i  = addr;
      wait_cycles(1);
      host_i.ale_n = 1'b0;  // address phase
      wait_cycles(STROBE_CYC);
      host_i.ale_n = 1'b1;
      wait_cycles(STROBE_CYC);
   endtask

   task automatic end_access();
      host_i.ce_n = 1'b1;
      wait_cycles(2);
   endtask

   task automatic write_byte(input logic [DATA_W-1:0] data);
      usb_data_i  = data;
      host_i.wr_n = 1'b0;
      wait_cycles(STROBE_CYC);
      host_i.wr_n = 1'b1;  // data taken on this edge
      wait_cycles(STROBE_CYC);
   endtask

   task automatic read_byte();
      host_i.rd_n = 1'b0;
      wait_cycles(STROBE_CYC);
      host_i.rd_n = 1'b1;
      wait_cycles(STROBE_CYC);
   endtask

   task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      start_access(addr);
      write_byte(data);
      end_access();
   endtask

   task automatic reg_read(input logic [ADDR_W-1:0] addr);
      start_access(addr);
      read_byte();
      end_access();
   endtask

   task automatic pulse_error(input logic [ERR_SRC_N-1:0] src);
      err_src_i = src;
      wait_cycles(1);
      err_src_i = '0;
      wait_cycles(STROBE_CYC);
   endtask

   task automatic wiggle_inputs(input int unsigned n);
      repeat (n) begin
         rnd           = xorshift32(rnd);
         sam_mosi_i    = rnd[0];
         sam_spck_i    = rnd[1];
         target_miso_i = rnd[2];
         wait_cycles(3);
      end
   endtask

   task automatic print_counts();
      $display("assertion failures: %0d, testbench errors: %0d", UUT.u_checker.fail_cnt,
               err_cnt);
   endtask

   always @(posedge clk_usb_buf) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYC) begin
         $display("timeout: test sequence did not finish within %0d cycles", TIMEOUT_CYC);
         err_cnt = err_cnt + 1;
         print_counts();
         $display("STATUS: FAIL");
         $finish;
      end
   end

   initial begin
      host_i        = '1;
      usb_addr_i    = '0;
      usb_data_i    = '0;
      sam_mosi_i    = 1'b0;
      sam_spck_i    = 1'b0;
      target_miso_i = 1'b0;
      err_src_i     = '0;
      pll_status_i  = 1'b1;
      led_glitch_i  = 1'b0;
      rnd           = SEED;
      arst_n_i      = 1'b0;
      wait_cycles(RESET_CYC);
      arst_n_i = 1'b1;
      wait_cycles(4);

      reg_read(REG_TARGET_CTRL);  // reset value
      repeat (4) begin
         rnd = xorshift32(rnd);
         reg_write(REG_TARGET_CTRL, rnd[DATA_W-1:0]);
         wiggle_inputs(3);
         reg_read(REG_TARGET_CTRL);
      end

      // second byte of a burst, then an unmapped address
      start_access(REG_TARGET_CTRL);
      read_byte();
      read_byte();
      end_access();
      reg_write(REG_UNMAPPED, 8'hff);
      reg_read(REG_UNMAPPED);

      // power off, programming, nRST drive high and low, off with programming
      reg_write(REG_TARGET_CTRL, 8'h01);
      wiggle_inputs(3);
      reg_write(REG_TARGET_CTRL, 8'h02);
      wiggle_inputs(6);
      reg_write(REG_TARGET_CTRL, 8'h0c);
      wiggle_inputs(3);
      reg_write(REG_TARGET_CTRL, 8'h04);
      wiggle_inputs(3);
      reg_write(REG_TARGET_CTRL, 8'h03);
      wiggle_inputs(3);

      // sticky flags and write-one-to-clear
      pulse_error(2'b01);
      reg_read(REG_STATUS);
      pulse_error(2'b10);
      pll_status_i = 1'b0;
      reg_read(REG_STATUS);
      reg_write(REG_STATUS, 8'h01);
      reg_read(REG_STATUS);
      reg_write(REG_STATUS, 8'h02);
      reg_read(REG_STATUS);

      // normal LED indication
      repeat (6) begin
         rnd          = xorshift32(rnd);
         pll_status_i = rnd[0];
         led_glitch_i = rnd[1];
         wait_cycles(4);
      end
      wait_cycles(8);

      print_counts();
      if (UUT.u_checker.fail_cnt == 0 && err_cnt == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

//--- project.f
rtl/husky_pkg.sv
rtl/usb_reg_bus.sv
rtl/reg_target_ctrl.sv
rtl/reg_status_leds.sv
rtl/husky_top.sv
dv/husky_checker.sv
dv/tb_husky_top.sv

//--- rtl/husky_pkg.sv
package husky_pkg;

   // bus widths
   localparam int unsigned ADDR_W      = 8;
   localparam int unsigned DATA_W      = 8;
   localparam int unsigned BYTECNT_W   = 7;
   localparam int unsigned HEARTBEAT_W = 25;

   // heartbeat bit used to flash the LEDs on error
   localparam int unsigned FLASH_BIT = 22;

   // register map
   localparam logic [ADDR_W-1:0] REG_TARGET_CTRL = 8'h20;
   localparam logic [ADDR_W-1:0] REG_STATUS      = 8'h21;

   // target control byte fields
   localparam int unsigned CTRL_POWER_OFF = 0;
   localparam int unsigned CTRL_AVRPROG   = 1;
   localparam int unsigned CTRL_NRST_EN   = 2;
   localparam int unsigned CTRL_NRST_VAL  = 3;

   localparam logic [DATA_W-1:0] CTRL_RESET_VALUE = 8'h01;  // target unpowered

   // status register layout
   localparam int unsigned ERR_SRC_N    = 2;
   localparam int unsigned STAT_PLL_BIT = ERR_SRC_N;  // just above the flags

   // register access as seen by the register blocks
   typedef struct packed {
      logic [ADDR_W-1:0]    addr;
      logic [BYTECNT_W-1:0] bytecnt;
      logic [DATA_W-1:0]    wdata;
      logic                 read;   // one cycle
      logic                 write;  // one cycle
   } reg_bus_t;

   // host strobes, all active low
   typedef struct packed {
      logic rd_n;
      logic wr_n;
      logic ce_n;
      logic ale_n;
   } host_pins_t;

endpackage

//--- rtl/husky_top.sv
module husky_top (
   input  logic                             clk_usb_buf,
   input  logic                             arst_n_i,
   // host register bus
   input  husky_pkg::host_pins_t            host_i,
   input  logic [husky_pkg::ADDR_W-1:0]     usb_addr_i,
   input  logic [husky_pkg::DATA_W-1:0]     usb_data_i,
   output logic [husky_pkg::DATA_W-1:0]     usb_data_o,
   output logic                             usb_data_oe_o,
   // SAM programming lines
   input  logic                             sam_mosi_i,
   input  logic                             sam_spck_i,
   output logic                             sam_miso_o,
   output logic                             sam_miso_oe_o,
   // target pins
   input  logic                             target_miso_i,
   output logic                             target_poweron_o,
   output logic                             target_nrst_o,
   output logic                             target_nrst_oe_o,
   output logic                             target_mosi_o,
   output logic                             target_mosi_oe_o,
   output logic                             target_sck_o,
   output logic                             target_sck_oe_o,
   // status
   input  logic [husky_pkg::ERR_SRC_N-1:0]  err_src_i,
   input  logic                             pll_status_i,
   input  logic                             led_glitch_i,
   output logic                             led_adc_o,
   output logic                             led_glitch_o
);
   import husky_pkg::*;

   reg_bus_t          reg_bus;
   logic [DATA_W-1:0] rdata_ctrl;
   logic [DATA_W-1:0] rdata_status;
   logic [DATA_W-1:0] rdata_merged;

   // unaddressed blocks return zero
   assign rdata_merged = rdata_ctrl | rdata_status;

   usb_reg_bus u_usb_reg_bus (
      .clk_usb_buf   (clk_usb_buf),
      .arst_n_i      (arst_n_i),
      .host_i        (host_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .rdata_i       (rdata_merged),
      .reg_bus_o     (reg_bus),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o)
   );

   reg_target_ctrl u_reg_target_ctrl (
      .clk_usb_buf      (clk_usb_buf),
      .arst_n_i         (arst_n_i),
      .reg_bus_i        (reg_bus),
      .sam_mosi_i       (sam_mosi_i),
      .sam_spck_i       (sam_spck_i),
      .target_miso_i    (target_miso_i),
      .rdata_o          (rdata_ctrl),
      .target_poweron_o (target_poweron_o),
      .target_nrst_o    (target_nrst_o),
      .target_nrst_oe_o (target_nrst_oe_o),
      .target_mosi_o    (target_mosi_o),
      .target_mosi_oe_o (target_mosi_oe_o),
      .target_sck_o     (target_sck_o),
      .target_sck_oe_o  (target_sck_oe_o),
      .sam_miso_o       (sam_miso_o),
      .sam_miso_oe_o    (sam_miso_oe_o)
   );

   reg_status_leds u_reg_status_leds (
      .clk_usb_buf  (clk_usb_buf),
      .arst_n_i     (arst_n_i),
      .reg_bus_i    (reg_bus),
      .err_src_i    (err_src_i),
      .pll_status_i (pll_status_i),
      .led_glitch_i (led_glitch_i),
      .rdata_o      (rdata_status),
      .led_adc_o    (led_adc_o),
      .led_glitch_o (led_glitch_o)
   );

endmodule

//--- rtl/reg_status_leds.sv
module reg_status_leds (
   input  logic                             clk_usb_buf,
   input  logic                             arst_n_i,
   input  husky_pkg::reg_bus_t              reg_bus_i,
   input  logic [husky_pkg::ERR_SRC_N-1:0]  err_src_i,
   input  logic                             pll_status_i,
   input  logic                             led_glitch_i,
   output logic [husky_pkg::DATA_W-1:0]     rdata_o,
   output logic                             led_adc_o,
   output logic                             led_glitch_o
);
   import husky_pkg::*;

   logic [ERR_SRC_N-1:0]   flags_q;
   logic [ERR_SRC_N-1:0]   clr_mask;
   logic [HEARTBEAT_W-1:0] heartbeat_q;
   logic                   sel;
   logic                   any_err;
   logic                   flash;

   assign sel = (reg_bus_i.addr == REG_STATUS);

   // write-one-to-clear
   assign clr_mask = (reg_bus_i.write && sel) ? reg_bus_i.wdata[ERR_SRC_N-1:0] : '0;

   // a new error wins over a clear in the same cycle
   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         flags_q <= '0;
      end else begin
         flags_q <= (flags_q & ~clr_mask) | err_src_i;
      end
   end

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         heartbeat_q <= '0;
      end else begin
         heartbeat_q <= heartbeat_q + 1'b1;  // free running
      end
   end

   always_comb begin
      rdata_o = '0;
      if (reg_bus_i.read && sel) begin
         rdata_o[ERR_SRC_N-1:0] = flags_q;
         rdata_o[STAT_PLL_BIT]  = pll_status_i;
      end
   end

   assign any_err = |flags_q;
   assign flash   = heartbeat_q[FLASH_BIT];

   // fast flash on any error, normal indication otherwise
   assign led_adc_o    = any_err ? flash : ~pll_status_i;
   assign led_glitch_o = any_err ? flash : led_glitch_i;

endmodule

//--- rtl/reg_target_ctrl.sv
module reg_target_ctrl (
   input  logic                          clk_usb_buf,
   input  logic                          arst_n_i,
   input  husky_pkg::reg_bus_t           reg_bus_i,
   input  logic                          sam_mosi_i,
   input  logic                          sam_spck_i,
   input  logic                          target_miso_i,
   output logic [husky_pkg::DATA_W-1:0]  rdata_o,
   output logic                          target_poweron_o,
   output logic                          target_nrst_o,
   output logic                          target_nrst_oe_o,
   output logic                          target_mosi_o,
   output logic                          target_mosi_oe_o,
   output logic                          target_sck_o,
   output logic                          target_sck_oe_o,
   output logic                          sam_miso_o,
   output logic                          sam_miso_oe_o
);
   import husky_pkg::*;

   logic [DATA_W-1:0] ctrl_q;
   logic              sel;
   logic              powered;
   logic              avrprog;
   logic              nrst_en;

   // only the first byte of a burst is mapped
   assign sel = (reg_bus_i.addr == REG_TARGET_CTRL) && (reg_bus_i.bytecnt == '0);

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ctrl_q <= CTRL_RESET_VALUE;
      end else if (reg_bus_i.write && sel) begin
         ctrl_q <= reg_bus_i.wdata;
      end
   end

   assign rdata_o = (reg_bus_i.read && sel) ? ctrl_q : '0;

   // every target enable is qualified by power
   assign powered = ~ctrl_q[CTRL_POWER_OFF];
   assign avrprog = powered & ctrl_q[CTRL_AVRPROG];
   assign nrst_en = powered & ctrl_q[CTRL_NRST_EN];

   assign target_poweron_o = powered;

   // nRST: held low while programming, else optional drive
   always_comb begin
      if (avrprog) begin
         target_nrst_oe_o = 1'b1;
         target_nrst_o    = 1'b0;
      end else if (nrst_en) begin
         target_nrst_oe_o = 1'b1;
         target_nrst_o    = ctrl_q[CTRL_NRST_VAL];
      end else begin
         target_nrst_oe_o = 1'b0;
         target_nrst_o    = 1'b0;  // floating
      end
   end

   // SPI programming lines pass through from the SAM
   assign target_mosi_oe_o = avrprog;
   assign target_mosi_o    = avrprog & sam_mosi_i;
   assign target_sck_oe_o  = avrprog;
   assign target_sck_o     = avrprog & sam_spck_i;

   // MISO back to the SAM does not depend on target power
   assign sam_miso_oe_o = ctrl_q[CTRL_AVRPROG];
   assign sam_miso_o    = target_miso_i;

endmodule

//--- rtl/usb_reg_bus.sv
module usb_reg_bus (
   input  logic                          clk_usb_buf,
   input  logic                          arst_n_i,
   input  husky_pkg::host_pins_t         host_i,
   input  logic [husky_pkg::ADDR_W-1:0]  usb_addr_i,
   input  logic [husky_pkg::DATA_W-1:0]  usb_data_i,
   input  logic [husky_pkg::DATA_W-1:0]  rdata_i,
   output husky_pkg::reg_bus_t           reg_bus_o,
   output logic [husky_pkg::DATA_W-1:0]  usb_data_o,
   output logic                          usb_data_oe_o
);
   import husky_pkg::*;

   // strobe synchroniser and edge-detect stage
   host_pins_t host_s1;
   host_pins_t host_s2;
   host_pins_t host_d;

   logic ale_fall;
   logic wr_rise;
   logic rd_fall;
   logic rd_rise;

   logic [ADDR_W-1:0]    addr_q;
   logic [BYTECNT_W-1:0] bytecnt_q;
   logic [DATA_W-1:0]    wdata_q;
   logic [DATA_W-1:0]    rdata_q;
   logic                 rd_stb_q;
   logic                 wr_stb_q;
   logic                 rd_active_q;

   // idle level of every strobe is high, so reset to ones
   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         host_s1 <= '1;
         host_s2 <= '1;
         host_d  <= '1;
      end else begin
         host_s1 <= host_i;
         host_s2 <= host_s1;
         host_d  <= host_s2;
      end
   end

   // edges only count while the chip is selected
   always_comb begin
      ale_fall = host_d.ale_n & ~host_s2.ale_n & ~host_s2.ce_n;
      wr_rise  = ~host_d.wr_n & host_s2.wr_n & ~host_s2.ce_n;
      rd_fall  = host_d.rd_n & ~host_s2.rd_n & ~host_s2.ce_n;
      rd_rise  = ~host_d.rd_n & host_s2.rd_n;
   end

   // one-cycle strobes
   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_stb_q <= 1'b0;
         rd_stb_q <= 1'b0;
      end else begin
         wr_stb_q <= wr_rise;
         rd_stb_q <= rd_fall;
      end
   end

   // address and write data, host holds them stable around the edge
   always_ff @(posedge clk_usb_buf) begin
      if (ale_fall) begin
         addr_q <= usb_addr_i;
      end
      if (wr_rise) begin
         wdata_q <= usb_data_i;
      end
      if (rd_stb_q) begin
         rdata_q <= rdata_i;  // merged read byte, one cycle after strobe
      end
   end

   // drive the bus until the host releases RDn
   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_active_q <= 1'b0;
      end else if (rd_stb_q) begin
         rd_active_q <= 1'b1;
      end else if (rd_rise) begin
         rd_active_q <= 1'b0;
      end
   end

   // byte counter, cleared by each address phase
   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         bytecnt_q <= '0;
      end else if (ale_fall) begin
         bytecnt_q <= '0;
      end else if (wr_stb_q || (rd_rise && rd_active_q)) begin
         bytecnt_q <= bytecnt_q + 1'b1;  // after the write strobe or at end of read
      end
   end

   always_comb begin
      reg_bus_o.addr    = addr_q;
      reg_bus_o.bytecnt = bytecnt_q;
      reg_bus_o.wdata   = wdata_q;
      reg_bus_o.read    = rd_stb_q;
      reg_bus_o.write   = wr_stb_q;
   end

   assign usb_data_o    = rdata_q;
   assign usb_data_oe_o = rd_active_q;

endmodule
